/* verilog/arm_pkg.sv */
package arm_pkg;

    typedef logic [31:0] word_t;      // register contents, operands, results
    typedef logic [3:0]  reg_idx_t;   // r0 .. r15
    typedef logic [3:0]  flags_t;     // {N, Z, C, V}

    // bit positions inside flags_t
    localparam int FLAG_N = 3;
    localparam int FLAG_Z = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // data-processing opcodes, ARM encoding of bits 24:21
    typedef enum logic [3:0] {
        AND = 4'b0000,
        EOR = 4'b0001,
        SUB = 4'b0010,
        RSB = 4'b0011,
        ADD = 4'b0100,
        ADC = 4'b0101,
        SBC = 4'b0110,
        RSC = 4'b0111,
        TST = 4'b1000,
        TEQ = 4'b1001,
        CMP = 4'b1010,
        CMN = 4'b1011,
        ORR = 4'b1100,
        MOV = 4'b1101,
        BIC = 4'b1110,
        MVN = 4'b1111
    } alu_op_t;

    // condition field, bits 31:28
    typedef enum logic [3:0] {
        EQ, NE, CS, CC, MI, PL, VS, VC,
        HI, LS, GE, LT, GT, LE, AL, NV
    } cond_t;

    localparam int COND_HI = 31;
    localparam int COND_LO = 28;
    localparam int IMM_BIT = 25;      // 1 = operand 2 is the immediate
    localparam int OP_HI   = 24;
    localparam int OP_LO   = 21;
    localparam int S_BIT   = 20;
    localparam int RN_HI   = 19;
    localparam int RN_LO   = 16;
    localparam int RD_HI   = 15;
    localparam int RD_LO   = 12;
    localparam int RM_HI   = 3;
    localparam int RM_LO   = 0;
    localparam int IMM_W   = 8;       // low byte, zero-extended

    // logical class leaves C and V as they were
    function automatic logic is_logical(alu_op_t op);
        return op inside {AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN};
    endfunction

endpackage

/* verilog/decoder.sv */
`timescale 1ns/100ps

module decoder (
    input  arm_pkg::word_t    instr,
    input  logic              valid,
    output arm_pkg::cond_t    cond,
    output arm_pkg::alu_op_t  op,
    output arm_pkg::reg_idx_t rn,
    output arm_pkg::reg_idx_t rm,
    output arm_pkg::reg_idx_t rd,
    output logic              use_imm,
    output arm_pkg::word_t    imm,
    output logic              set_flags,
    output logic              writes_rd
);
    import arm_pkg::*;

    logic is_test;     // TST/TEQ/CMP/CMN, flags only

    // plain field slicing
    assign cond = cond_t'(instr[COND_HI:COND_LO]);
    assign op   = alu_op_t'(instr[OP_HI:OP_LO]);
    assign rn   = instr[RN_HI:RN_LO];
    assign rd   = instr[RD_HI:RD_LO];
    assign rm   = instr[RM_HI:RM_LO];

    assign use_imm   = instr[IMM_BIT];
    assign set_flags = instr[S_BIT];

    // rotate field ignored, byte goes in as is
    assign imm = {{($bits(word_t) - IMM_W){1'b0}}, instr[IMM_W-1:0]};

    assign is_test = op inside {TST, TEQ, CMP, CMN};

    // bubble never claims a destination, so forwarding ignores it
    assign writes_rd = valid && !is_test;

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic              clk,
    input  logic              Reset,
    input  arm_pkg::reg_idx_t raddr_a,
    input  arm_pkg::reg_idx_t raddr_b,
    input  logic              we,
    input  arm_pkg::reg_idx_t waddr,
    input  arm_pkg::word_t    wdata,
    output arm_pkg::word_t    rdata_a,
    output arm_pkg::word_t    rdata_b
);
    import arm_pkg::*;

    localparam int NREGS = 2 ** $bits(reg_idx_t);

    word_t regs [NREGS];

    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
        begin
            for (int i = 0; i < NREGS; i++)
                regs[i] <= '0;   // all registers read zero out of reset
        end
        else if (we)
            regs[waddr] <= wdata;
    end

    // async read, same-cycle write is bypassed outside
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

/* verilog/forward_unit.sv */
`timescale 1ns/100ps

module forward_unit (
    input  arm_pkg::reg_idx_t rn,
    input  arm_pkg::reg_idx_t rm,
    input  arm_pkg::word_t    rf_a,
    input  arm_pkg::word_t    rf_b,
    input  logic              ex_we,
    input  logic              wb_we,
    input  arm_pkg::reg_idx_t ex_rd,
    input  arm_pkg::reg_idx_t wb_rd,
    input  arm_pkg::word_t    ex_result,
    input  arm_pkg::word_t    wb_result,
    output arm_pkg::word_t    op_a,
    output arm_pkg::word_t    op_b
);
    import arm_pkg::*;

    // youngest producer wins: EX, then WB, then the array
    function automatic word_t pick(reg_idx_t src, word_t rf_val);
        word_t val;
        if (ex_we && ex_rd == src)
            val = ex_result;        // result still in the ALU
        else if (wb_we && wb_rd == src)
            val = wb_result;        // lands in the array at the end of this cycle
        else
            val = rf_val;
        return val;
    endfunction

    always_comb
    begin
        op_a = pick(rn, rf_a);
        op_b = pick(rm, rf_b);     // used only when operand 2 is a register
    end

endmodule

/* verilog/alu.sv */
`timescale 1ns/100ps

module alu (
    input  arm_pkg::alu_op_t op,
    input  arm_pkg::word_t   a,
    input  arm_pkg::word_t   b,
    input  logic             carry_in,
    output arm_pkg::word_t   result,
    output arm_pkg::flags_t  flags_out
);
    import arm_pkg::*;

    word_t       add_x;       // adder operands after swap/invert
    word_t       add_y;
    logic        add_cin;
    logic [32:0] sum;
    word_t       logic_res;
    logic        logical;

    // every arithmetic op as x + y + cin, subtract is x + ~y + 1
    always_comb
    begin
        add_x   = a;
        add_y   = b;
        add_cin = 1'b0;
        case (op)
            SUB, CMP:
            begin
                add_y   = ~b;
                add_cin = 1'b1;
            end
            RSB:
            begin
                add_x   = b;
                add_y   = ~a;
                add_cin = 1'b1;
            end
            ADC:      add_cin = carry_in;
            SBC:
            begin
                add_y   = ~b;
                add_cin = carry_in;   // borrow is !C
            end
            RSC:
            begin
                add_x   = b;
                add_y   = ~a;
                add_cin = carry_in;
            end
            default:  add_cin = 1'b0; // ADD, CMN and the logical ops
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + {32'd0, add_cin};

    always_comb
    begin
        case (op)
            AND, TST: logic_res = a & b;
            EOR, TEQ: logic_res = a ^ b;
            ORR:      logic_res = a | b;
            MOV:      logic_res = b;
            BIC:      logic_res = a & ~b;
            MVN:      logic_res = ~b;
            default:  logic_res = '0;
        endcase
    end

    assign logical = is_logical(op);
    assign result  = logical ? logic_res : sum[31:0];

    assign flags_out[FLAG_N] = result[31];
    assign flags_out[FLAG_Z] = (result == '0);
    assign flags_out[FLAG_C] = logical ? carry_in : sum[32];   // C set = no borrow
    // signed overflow, same operand signs but result sign differs
    // logical V comes back from the status register in the core
    assign flags_out[FLAG_V] = !logical && (add_x[31] == add_y[31]) &&
                               (sum[31] != add_x[31]);

endmodule

/* verilog/flag_unit.sv */
`timescale 1ns/100ps

module flag_unit (
    input  logic             clk,
    input  logic             Reset,
    input  arm_pkg::cond_t   cond,
    input  logic             update,
    input  arm_pkg::flags_t  new_flags,
    output arm_pkg::flags_t  flags,
    output logic             passed
);
    import arm_pkg::*;

    logic n;
    logic z;
    logic c;
    logic v;

    // status register, written on the edge that ends EX
    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
            flags <= '0;
        else if (update)
            flags <= new_flags;
    end

    assign n = flags[FLAG_N];
    assign z = flags[FLAG_Z];
    assign c = flags[FLAG_C];
    assign v = flags[FLAG_V];

    // ARM condition table
    always_comb
    begin
        case (cond)
            EQ:      passed = z;
            NE:      passed = !z;
            CS:      passed = c;             // unsigned higher or same
            CC:      passed = !c;
            MI:      passed = n;
            PL:      passed = !n;
            VS:      passed = v;
            VC:      passed = !v;
            HI:      passed = c && !z;
            LS:      passed = !c || z;
            GE:      passed = (n == v);
            LT:      passed = (n != v);
            GT:      passed = !z && (n == v);
            LE:      passed = z || (n != v);
            AL:      passed = 1'b1;
            default: passed = 1'b0;          // NV
        endcase
    end

endmodule

/* verilog/pipeline_core.sv */
`timescale 1ns/100ps

module pipeline_core (
    input  logic              clk,
    input  logic              Reset,
    input  logic              in_valid,
    input  arm_pkg::word_t    in_instr,
    output logic              wb_valid,
    output arm_pkg::reg_idx_t wb_rd,
    output arm_pkg::word_t    wb_data,
    output arm_pkg::flags_t   flags
);
    import arm_pkg::*;

    // ID stage
    logic     id_valid;
    word_t    id_instr;
    cond_t    id_cond;
    alu_op_t  id_op;
    reg_idx_t id_rn;
    reg_idx_t id_rm;
    reg_idx_t id_rd;
    logic     id_use_imm;
    word_t    id_imm;
    logic     id_set_flags;
    logic     id_writes_rd;
    word_t    rf_a;
    word_t    rf_b;
    word_t    fwd_a;
    word_t    fwd_b;

    // EX stage
    logic     ex_valid;
    cond_t    ex_cond;
    alu_op_t  ex_op;
    reg_idx_t ex_rd;
    logic     ex_use_imm;
    word_t    ex_imm;
    logic     ex_set_flags;
    logic     ex_writes_rd;
    word_t    ex_a;
    word_t    ex_b;
    word_t    alu_b;
    word_t    alu_result;
    flags_t   alu_flags;
    flags_t   ex_new_flags;
    logic     ex_passed;
    logic     ex_we;
    logic     flag_update;

    // WB stage
    logic     exwb_passed;       // valid and condition passed
    logic     exwb_writes_rd;
    reg_idx_t exwb_rd;
    word_t    exwb_result;
    logic     exwb_we;

    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
            id_valid <= 1'b0;
        else
            id_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
            id_instr <= in_instr;   // held between strobes
    end

    decoder i_decoder (
        .instr     (id_instr),
        .valid     (id_valid),
        .cond      (id_cond),
        .op        (id_op),
        .rn        (id_rn),
        .rm        (id_rm),
        .rd        (id_rd),
        .use_imm   (id_use_imm),
        .imm       (id_imm),
        .set_flags (id_set_flags),
        .writes_rd (id_writes_rd)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .Reset   (Reset),
        .raddr_a (id_rn),
        .raddr_b (id_rm),
        .we      (exwb_we),
        .waddr   (exwb_rd),
        .wdata   (exwb_result),
        .rdata_a (rf_a),
        .rdata_b (rf_b)
    );

    forward_unit i_forward_unit (
        .rn        (id_rn),
        .rm        (id_rm),
        .rf_a      (rf_a),
        .rf_b      (rf_b),
        .ex_we     (ex_we),
        .wb_we     (exwb_we),
        .ex_rd     (ex_rd),
        .wb_rd     (exwb_rd),
        .ex_result (alu_result),
        .wb_result (exwb_result),
        .op_a      (fwd_a),
        .op_b      (fwd_b)
    );

    // ID/EX register, control bits
    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
        begin
            ex_valid     <= 1'b0;
            ex_set_flags <= 1'b0;
            ex_writes_rd <= 1'b0;
        end
        else
        begin
            ex_valid     <= id_valid;
            ex_set_flags <= id_set_flags;
            ex_writes_rd <= id_writes_rd;   // already cleared for bubbles
        end
    end

    // ID/EX payload
    always_ff @(posedge clk)
    begin
        ex_cond    <= id_cond;
        ex_op      <= id_op;
        ex_rd      <= id_rd;
        ex_use_imm <= id_use_imm;
        ex_imm     <= id_imm;
        ex_a       <= fwd_a;
        ex_b       <= fwd_b;
    end

    assign alu_b = ex_use_imm ? ex_imm : ex_b;   // operand 2 select

    alu i_alu (
        .op        (ex_op),
        .a         (ex_a),
        .b         (alu_b),
        .carry_in  (flags[FLAG_C]),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    // logical ops keep the old V
    always_comb
    begin
        ex_new_flags         = alu_flags;
        ex_new_flags[FLAG_V] = is_logical(ex_op) ? flags[FLAG_V] : alu_flags[FLAG_V];
    end

    assign flag_update = ex_valid && ex_passed && ex_set_flags;
    assign ex_we       = ex_valid && ex_passed && ex_writes_rd;

    flag_unit i_flag_unit (
        .clk       (clk),
        .Reset     (Reset),
        .cond      (ex_cond),
        .update    (flag_update),
        .new_flags (ex_new_flags),
        .flags     (flags),
        .passed    (ex_passed)
    );

    // EX/WB register
    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
        begin
            exwb_passed    <= 1'b0;
            exwb_writes_rd <= 1'b0;
        end
        else
        begin
            exwb_passed    <= ex_valid && ex_passed;
            exwb_writes_rd <= ex_writes_rd;
        end
    end

    always_ff @(posedge clk)
    begin
        exwb_rd     <= ex_rd;
        exwb_result <= alu_result;
    end

    assign exwb_we = exwb_passed && exwb_writes_rd;

    // write report, same edge as the array write
    always_ff @(posedge clk or posedge Reset)
    begin
        if (Reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= exwb_we;   // one-cycle strobe
    end

    always_ff @(posedge clk)
    begin
        wb_rd   <= exwb_rd;
        wb_data <= exwb_result;
    end

endmodule

/* verification/core_asserts.sv */
`timescale 1ns/100ps

module core_asserts (
    input logic            clk,
    input logic            Reset,
    input logic            in_valid,
    input logic            wb_valid,
    input arm_pkg::flags_t flags
);

    // strobe seen at edge t gives a report that is set on t+3 and sampled on t+4
    a_wb_after_strobe: assert property (
        @(posedge clk) disable iff (Reset)
        wb_valid |-> $past(in_valid, 4)
    ) else $error("wb_valid without an instruction strobe four edges earlier");

    a_wb_low_in_reset: assert property (
        @(posedge clk) Reset |-> !wb_valid
    ) else $error("wb_valid high while Reset is asserted");

    // cleared valid bits keep wb_valid low for four edges after reset
    a_wb_low_after_reset: assert property (
        @(posedge clk) $past(Reset, 4) |-> !wb_valid
    ) else $error("wb_valid high before the pipeline could refill after reset");

    // status loads at the end of EX two edges after capture
    a_flags_stable: assert property (
        @(posedge clk) disable iff (Reset)
        !$stable(flags) |-> $past(in_valid, 3)
    ) else $error("flags changed with no instruction in EX");

endmodule

bind pipeline_core core_asserts i_core_asserts (
    .clk      (clk),
    .Reset    (Reset),
    .in_valid (in_valid),
    .wb_valid (wb_valid),
    .flags    (flags)
);

/* verification/core_tb.sv */
`timescale 1ns/100ps

module core_tb;
    import arm_pkg::*;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 5;
    localparam int          NUM_ROWS     = 92;     // rows in the instruction table
    localparam int          MAX_GAP      = 3;      // idle cycles between strobes
    localparam int          RAND_GAP     = -1;     // row gap drawn at random
    localparam int          DRAIN_CYCLES = 6;      // last strobe to last possible report
    localparam logic [31:0] RAND_SEED    = 32'hc706;

    typedef struct packed {
        word_t    instr;
        int       gap;      // idle cycles before this strobe
        logic     wr;       // a register write is reported
        reg_idx_t rd;
        word_t    data;
    } row_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } write_t;

    logic     clk;
    logic     Reset;
    logic     in_valid;
    word_t    in_instr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    flags_t   flags;

    row_t     rows [NUM_ROWS];
    int       n_rows;
    write_t   exp_q [$];      // writes still to be reported, program order
    int       writes_seen;

    pipeline_core i_pipeline_core (
        .clk      (clk),
        .Reset    (Reset),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .flags    (flags)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // data-processing word, operand 2 = rm, shift field zero
    function automatic word_t enc_reg(cond_t c, alu_op_t op, int s, int rn, int rd, int rm);
        return {c, 2'b00, 1'b0, op, (s != 0), 4'(rn), 4'(rd), 8'h00, 4'(rm)};
    endfunction

    // operand 2 = 8-bit immediate, rotate zero
    function automatic word_t enc_imm(cond_t c, alu_op_t op, int s, int rn, int rd,
                                      logic [7:0] imm);
        return {c, 2'b00, 1'b1, op, (s != 0), 4'(rn), 4'(rd), 4'h0, imm};
    endfunction

    task automatic add_row(word_t instr, int gap, int has_write, int rd, word_t data);
        if (n_rows < NUM_ROWS)
            rows[n_rows] = row_t'{instr: instr, gap: gap, wr: (has_write != 0),
                                  rd: 4'(rd), data: data};
        n_rows++;
    endtask

    // MOV r9, #(base + cond) under every condition, mask bit set = passes
    task automatic add_sweep(logic [15:0] pass_mask, int base);
        for (int c = 0; c < 16; c++)
            add_row(enc_imm(cond_t'(c), MOV, 0, 0, 9, 8'(base + c)), RAND_GAP,
                    int'(pass_mask[c]), 9, word_t'(base + c));
    endtask

    task automatic build_table();
        add_row(enc_reg(AL, ADD, 0, 0, 2, 1), RAND_GAP, 1, 2, 32'h0);     // fresh regs read 0
        add_row(enc_imm(AL, MOV, 0, 0, 1, 8'h5A), RAND_GAP, 1, 1, 32'h5A);
        add_row(enc_imm(AL, MOV, 0, 0, 2, 8'h0F), RAND_GAP, 1, 2, 32'h0F);
        add_row(enc_imm(AL, MOV, 0, 0, 3, 8'hFF), RAND_GAP, 1, 3, 32'hFF);
        // register form, r1 = 0x5A, r2 = 0x0F, C clear
        add_row(enc_reg(AL, AND, 0, 1, 4, 2), RAND_GAP, 1, 4, 32'h0A);
        add_row(enc_reg(AL, EOR, 0, 1, 5, 2), RAND_GAP, 1, 5, 32'h55);
        add_row(enc_reg(AL, SUB, 0, 1, 6, 2), RAND_GAP, 1, 6, 32'h4B);
        add_row(enc_reg(AL, RSB, 0, 1, 7, 2), RAND_GAP, 1, 7, 32'hFFFF_FFB5);
        add_row(enc_reg(AL, ADD, 0, 1, 8, 2), RAND_GAP, 1, 8, 32'h69);
        add_row(enc_reg(AL, ADC, 0, 1, 9, 2), RAND_GAP, 1, 9, 32'h69);    // no carry in
        add_row(enc_reg(AL, SBC, 0, 1, 10, 2), RAND_GAP, 1, 10, 32'h4A);  // borrow one
        add_row(enc_reg(AL, RSC, 0, 1, 11, 2), RAND_GAP, 1, 11, 32'hFFFF_FFB4);
        add_row(enc_reg(AL, ORR, 0, 1, 12, 2), RAND_GAP, 1, 12, 32'h5F);
        add_row(enc_reg(AL, MOV, 0, 0, 13, 2), RAND_GAP, 1, 13, 32'h0F);
        add_row(enc_reg(AL, BIC, 0, 1, 14, 2), RAND_GAP, 1, 14, 32'h50);
        add_row(enc_reg(AL, MVN, 0, 0, 15, 2), RAND_GAP, 1, 15, 32'hFFFF_FFF0);
        // test ops without S, no write, flags untouched
        add_row(enc_reg(AL, TST, 0, 1, 4, 2), RAND_GAP, 0, 0, 32'h0);
        add_row(enc_reg(AL, CMP, 0, 1, 4, 2), RAND_GAP, 0, 0, 32'h0);
        add_row(enc_imm(AL, TEQ, 0, 3, 4, 8'h3C), RAND_GAP, 0, 0, 32'h0);
        add_row(enc_imm(AL, CMN, 0, 3, 4, 8'h3C), RAND_GAP, 0, 0, 32'h0);
        // immediate form, r3 = 0xFF, C still clear since CMP had no S
        add_row(enc_imm(AL, AND, 0, 3, 4, 8'h3C), RAND_GAP, 1, 4, 32'h3C);
        add_row(enc_imm(AL, EOR, 0, 3, 5, 8'h3C), RAND_GAP, 1, 5, 32'hC3);
        add_row(enc_imm(AL, SUB, 0, 3, 6, 8'h3C), RAND_GAP, 1, 6, 32'hC3);
        add_row(enc_imm(AL, RSB, 0, 3, 7, 8'h3C), RAND_GAP, 1, 7, 32'hFFFF_FF3D);
        add_row(enc_imm(AL, ADD, 0, 3, 8, 8'h3C), RAND_GAP, 1, 8, 32'h13B);
        add_row(enc_imm(AL, ORR, 0, 1, 9, 8'h81), RAND_GAP, 1, 9, 32'hDB);
        add_row(enc_imm(AL, BIC, 0, 3, 10, 8'h3C), RAND_GAP, 1, 10, 32'hC3);
        add_row(enc_imm(AL, MVN, 0, 0, 11, 8'h3C), RAND_GAP, 1, 11, 32'hFFFF_FFC3);
        add_row(enc_imm(AL, MOV, 0, 0, 12, 8'h80), RAND_GAP, 1, 12, 32'h80);
        add_row(enc_imm(AL, ADC, 0, 3, 13, 8'h01), RAND_GAP, 1, 13, 32'h100);
        add_row(enc_imm(AL, SBC, 0, 3, 14, 8'h01), RAND_GAP, 1, 14, 32'hFD);
        add_row(enc_imm(AL, RSC, 0, 3, 15, 8'h01), RAND_GAP, 1, 15, 32'hFFFF_FF01);
        // dependent chain, fixed gaps
        add_row(enc_imm(AL, MOV, 0, 0, 1, 8'h11), RAND_GAP, 1, 1, 32'h11);
        add_row(enc_reg(AL, ADD, 0, 1, 2, 1), 0, 1, 2, 32'h22);           // both from EX
        add_row(enc_reg(AL, ADD, 0, 2, 3, 1), 0, 1, 3, 32'h33);           // EX and WB
        add_row(enc_imm(AL, ADD, 0, 3, 4, 8'h01), 1, 1, 4, 32'h34);       // from WB
        add_row(enc_reg(AL, SUB, 0, 4, 5, 1), 2, 1, 5, 32'h23);           // array
        add_row(enc_reg(AL, EOR, 0, 5, 5, 4), 0, 1, 5, 32'h17);
        add_row(enc_imm(AL, ADD, 0, 5, 6, 8'h00), 0, 1, 6, 32'h17);       // EX beats WB
        // flag setting, then the condition table
        add_row(enc_imm(AL, MOV, 1, 0, 7, 8'h00), RAND_GAP, 1, 7, 32'h0); // NZCV 0100
        add_row(enc_imm(AL, MOV, 0, 0, 8, 8'h05), RAND_GAP, 1, 8, 32'h5); // no S, kept
        add_sweep(16'h66A9, 'h10);
        add_row(enc_imm(AL, CMP, 1, 11, 0, 8'h01), RAND_GAP, 0, 0, 32'h0); // NZCV 1010
        add_sweep(16'h6996, 'h30);
        add_row(enc_imm(AL, MOV, 1, 0, 10, 8'h05), RAND_GAP, 1, 10, 32'h5); // NZCV 0010
        add_sweep(16'h55A6, 'h50);
        add_row(enc_imm(AL, ADC, 0, 0, 12, 8'h10), RAND_GAP, 1, 12, 32'h11); // C kept set
    endtask

    task automatic check_write();
        write_t exp;
        if (exp_q.size() == 0)
            fail_run($sformatf("unexpected write of %h to r%0d at %0t, none was pending",
                               wb_data, wb_rd, $time));
        else
        begin
            exp = exp_q.pop_front();
            writes_seen++;
            assert (wb_rd == exp.rd && wb_data == exp.data)
            else fail_run($sformatf("mismatch at %0t: write %0d expected r%0d = %h, got r%0d = %h",
                                    $time, writes_seen, exp.rd, exp.data, wb_rd, wb_data));
        end
    endtask

    // reports are stable away from the rising edge
    always @(negedge clk)
    begin
        if (!Reset && wb_valid)
            check_write();
    end

    initial
    begin
        #(CLK_PERIOD * (NUM_ROWS * 7 + 20));
        fail_run("timeout, the instruction table did not finish in time");
    end

    initial
    begin
        int gap;
        Reset       = 1'b1;
        in_valid    = 1'b0;
        in_instr    = '0;
        n_rows      = 0;
        writes_seen = 0;
        void'($urandom(RAND_SEED));
        build_table();
        if (n_rows != NUM_ROWS)
            fail_run($sformatf("instruction table holds %0d rows instead of %0d",
                               n_rows, NUM_ROWS));
        repeat (RESET_CYCLES) @(posedge clk);
        Reset <= 1'b0;
        @(negedge clk);
        assert (flags == 4'b0000)
        else fail_run($sformatf("mismatch at %0t: flags %b after reset, expected 0000",
                                $time, flags));
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            gap = (rows[i].gap == RAND_GAP) ? int'($urandom_range(MAX_GAP, 0)) : rows[i].gap;
            repeat (gap)
            begin
                @(posedge clk);
                in_valid <= 1'b0;          // bubble
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_instr <= rows[i].instr;
            if (rows[i].wr)
                exp_q.push_back(write_t'{rd: rows[i].rd, data: rows[i].data});
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);   // last report lands within this
        @(negedge clk);
        assert (flags == 4'b0010)
        else fail_run($sformatf("mismatch at %0t: final flags %b, expected 0010",
                                $time, flags));
        if (exp_q.size() == 0)
        begin
            $display("Test OK");
            $finish;
        end
        else
            fail_run($sformatf("%0d expected register writes were never reported",
                               exp_q.size()));
    end

endmodule

/* sources.f */
verilog/arm_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/forward_unit.sv
verilog/alu.sv
verilog/flag_unit.sv
verilog/pipeline_core.sv
verification/core_asserts.sv
verification/core_tb.sv

/* Bender.yml */
package:
  name: pipeline_core

sources:
  - files:
      - verilog/arm_pkg.sv
      - verilog/decoder.sv
      - verilog/reg_file.sv
      - verilog/forward_unit.sv
      - verilog/alu.sv
      - verilog/flag_unit.sv
      - verilog/pipeline_core.sv
  - target: test
    files:
      - verification/core_asserts.sv
      - verification/core_tb.sv
